// File: src/mem_types_pkg.sv
package mem_types_pkg;

	// SRAM geometry seen from the CPU side
	localparam int MEM_ADDR_W = 18;
	localparam int MEM_WORD_W = 16;

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
	typedef logic [MEM_WORD_W-1:0] mem_word_t;

	// Execute stage request, held until exe_done rises
	typedef struct packed {
		logic      req;
		logic      rd;
		logic      wr;
		mem_addr_t addr;
		mem_word_t wdata;
	} exe_req_t;

	// SRAM control pins, all active low
	typedef struct packed {
		logic ce_n;
		logic oe_n;
		logic we_n;
	} sram_ctl_t;

	localparam sram_ctl_t SRAM_CTL_IDLE = '{ce_n: 1'b0, oe_n: 1'b1, we_n: 1'b1};

endpackage

// File: src/ram_timing_pkg.sv
package ram_timing_pkg;

	// Pacing counter width, one phase step is 2**RAM_DIV_BITS clocks
	localparam int RAM_DIV_BITS = 2;

	// Bus phases of one SRAM access
	typedef enum logic [3:0] {
		PH_IDLE    = 4'd0,
		// Execute read
		PH_EXE_RD1 = 4'd1,
		PH_EXE_RD2 = 4'd2,
		PH_EXE_RD3 = 4'd3,
		// Fetch read
		PH_IF_RD1  = 4'd4,
		PH_IF_RD2  = 4'd5,
		PH_IF_RD3  = 4'd6,
		// Execute write
		PH_WR1     = 4'd7,
		PH_WR2     = 4'd8,
		PH_WR3     = 4'd9,
		// Sticky, left only by reset
		PH_ERROR   = 4'd15
	} ram_phase_t;

endpackage

// File: src/ram_ctrl.sv
`timescale 1ns/1ps

module ram_ctrl (
	input  logic                     clk,
	input  logic                     rst,
	input  mem_types_pkg::exe_req_t  exe,
	input  logic                     if_req,
	output logic                     load_addr,
	output logic                     addr_sel,
	output logic                     drive,
	output logic                     capture_exe,
	output logic                     capture_if,
	output mem_types_pkg::sram_ctl_t sram_ctl,
	output logic                     exe_done,
	output logic                     if_done,
	output logic                     err
);
	import mem_types_pkg::*;
	import ram_timing_pkg::*;

	logic [RAM_DIV_BITS-1:0] cnt;
	logic                    tick;

	ram_phase_t phase;
	ram_phase_t phase_next;

	sram_ctl_t ctl_next;
	logic      drive_next;

	logic exe_start;
	logic if_start;
	logic exe_end;
	logic if_end;

	//////////////////////////////////////////////////
	// Pacing
	//////////////////////////////////////////////////

	// Free running from reset
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// First cycle after the counter wraps
	assign tick = (cnt == '0);

	//////////////////////////////////////////////////
	// Arbitration and phase sequence
	//////////////////////////////////////////////////

	always_comb begin
		phase_next = phase;
		case (phase)
			PH_IDLE: begin
				// Execute wins over fetch
				if (exe.req) begin
					if (exe.rd) begin
						phase_next = PH_EXE_RD1;
					end else if (exe.wr) begin
						phase_next = PH_WR1;
					end else begin
						phase_next = PH_ERROR;
					end
				end else if (if_req) begin
					phase_next = PH_IF_RD1;
				end
			end

			PH_EXE_RD1: phase_next = PH_EXE_RD2;
			PH_EXE_RD2: phase_next = PH_EXE_RD3;
			PH_EXE_RD3: phase_next = PH_IDLE;

			PH_IF_RD1:  phase_next = PH_IF_RD2;
			PH_IF_RD2:  phase_next = PH_IF_RD3;
			PH_IF_RD3:  phase_next = PH_IDLE;

			PH_WR1:     phase_next = PH_WR2;
			PH_WR2:     phase_next = PH_WR3;
			PH_WR3:     phase_next = PH_IDLE;

			PH_ERROR:   phase_next = PH_ERROR;

			default:    phase_next = PH_ERROR;
		endcase
	end

	// Access boundaries, only meaningful at a tick
	assign exe_start = (phase == PH_IDLE) &&
		(phase_next == PH_EXE_RD1 || phase_next == PH_WR1);
	assign if_start  = (phase == PH_IDLE) && (phase_next == PH_IF_RD1);
	assign exe_end   = (phase == PH_EXE_RD3) || (phase == PH_WR3);
	assign if_end    = (phase == PH_IF_RD3);

	//////////////////////////////////////////////////
	// Pin and strobe decode
	//////////////////////////////////////////////////

	// Decoded from the next phase so the pins line up with phase
	always_comb begin
		ctl_next   = SRAM_CTL_IDLE;
		drive_next = 1'b0;
		case (phase_next)
			PH_EXE_RD1, PH_EXE_RD2, PH_EXE_RD3,
			PH_IF_RD1, PH_IF_RD2, PH_IF_RD3: begin
				ctl_next.oe_n = 1'b0;
			end

			// Data is on the bus one phase before and after the pulse
			PH_WR1, PH_WR3: begin
				drive_next = 1'b1;
			end
			PH_WR2: begin
				drive_next    = 1'b1;
				ctl_next.we_n = 1'b0;
			end

			// Chip deselected while stuck
			PH_ERROR: begin
				ctl_next.ce_n = 1'b1;
			end

			default: begin
				ctl_next = SRAM_CTL_IDLE;
			end
		endcase
	end

	// Address and write data latched as the first phase is entered
	assign load_addr = tick && (exe_start || if_start);
	assign addr_sel  = exe.req;

	// Read data sampled at the end of phase 3
	assign capture_exe = tick && (phase == PH_EXE_RD3);
	assign capture_if  = tick && (phase == PH_IF_RD3);

	assign err = (phase == PH_ERROR);

	//////////////////////////////////////////////////
	// State and done levels
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			phase    <= PH_IDLE;
			sram_ctl <= SRAM_CTL_IDLE;
			drive    <= 1'b0;
			exe_done <= 1'b1;
			if_done  <= 1'b1;
		end else if (tick) begin
			phase    <= phase_next;
			sram_ctl <= ctl_next;
			drive    <= drive_next;

			// Done drops on entry to phase 1, rises on exit from phase 3
			if (exe_start) begin
				exe_done <= 1'b0;
			end else if (exe_end) begin
				exe_done <= 1'b1;
			end

			if (if_start) begin
				if_done <= 1'b0;
			end else if (if_end) begin
				if_done <= 1'b1;
			end
		end
	end

endmodule

// File: src/ram_bus_io.sv
`timescale 1ns/1ps

module ram_bus_io (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     load_addr,
	input  logic                     addr_sel,
	input  logic                     drive,
	input  logic                     capture_exe,
	input  logic                     capture_if,
	input  mem_types_pkg::mem_addr_t exe_addr,
	input  mem_types_pkg::mem_word_t exe_wdata,
	input  mem_types_pkg::mem_addr_t if_addr,
	output mem_types_pkg::mem_addr_t sram_addr,
	inout  wire mem_types_pkg::mem_word_t sram_dq,
	output mem_types_pkg::mem_word_t exe_rdata,
	output mem_types_pkg::mem_word_t if_rdata
);
	import mem_types_pkg::*;

	mem_addr_t addr_mux;
	mem_word_t wdata_q;

	// High selects the execute address
	assign addr_mux = addr_sel ? exe_addr : if_addr;

	// Address pins come straight from this register
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			sram_addr <= '0;
		end else if (load_addr) begin
			sram_addr <= addr_mux;
		end
	end

	// Write data taken with the address
	always_ff @(posedge clk) begin
		if (load_addr) begin
			wdata_q <= exe_wdata;
		end
	end

	assign sram_dq = drive ? wdata_q : 'z;

	//////////////////////////////////////////////////
	// Read results, held until the next read
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (capture_exe) begin
			exe_rdata <= sram_dq;
		end
	end

	always_ff @(posedge clk) begin
		if (capture_if) begin
			if_rdata <= sram_dq;
		end
	end

endmodule

// File: src/mem_port_top.sv
`timescale 1ns/1ps

module mem_port_top (
	input  logic                     clk,
	input  logic                     rst,
	input  mem_types_pkg::exe_req_t  exe,
	input  logic                     if_req,
	input  mem_types_pkg::mem_addr_t if_addr,
	output logic                     exe_done,
	output mem_types_pkg::mem_word_t exe_rdata,
	output logic                     if_done,
	output mem_types_pkg::mem_word_t if_rdata,
	output logic                     err,
	output mem_types_pkg::mem_addr_t sram_addr,
	inout  wire mem_types_pkg::mem_word_t sram_dq,
	output mem_types_pkg::sram_ctl_t sram_ctl
);

	// Controller to bus block strobes
	logic load_addr;
	logic addr_sel;
	logic drive;
	logic capture_exe;
	logic capture_if;

	ram_ctrl i_ctrl (
		.clk         (clk),
		.rst         (rst),
		.exe         (exe),
		.if_req      (if_req),
		.load_addr   (load_addr),
		.addr_sel    (addr_sel),
		.drive       (drive),
		.capture_exe (capture_exe),
		.capture_if  (capture_if),
		.sram_ctl    (sram_ctl),
		.exe_done    (exe_done),
		.if_done     (if_done),
		.err         (err)
	);

	// Address and write data split out of the execute request
	ram_bus_io i_bus (
		.clk         (clk),
		.rst         (rst),
		.load_addr   (load_addr),
		.addr_sel    (addr_sel),
		.drive       (drive),
		.capture_exe (capture_exe),
		.capture_if  (capture_if),
		.exe_addr    (exe.addr),
		.exe_wdata   (exe.wdata),
		.if_addr     (if_addr),
		.sram_addr   (sram_addr),
		.sram_dq     (sram_dq),
		.exe_rdata   (exe_rdata),
		.if_rdata    (if_rdata)
	);

endmodule

// File: tests/sram_model.sv
`timescale 1ns/1ps

module sram_model (
	input  mem_types_pkg::mem_addr_t      addr,
	inout  wire mem_types_pkg::mem_word_t dq,
	input  logic                          ce_n,
	input  logic                          oe_n,
	input  logic                          we_n
);
	import mem_types_pkg::*;

	mem_word_t mem [0:(1 << MEM_ADDR_W)-1];

	// Read path, only while selected and not writing
	assign dq = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

	// Data taken at the end of the write pulse
	always @(posedge we_n) begin
		if (!ce_n) begin
			mem[addr] <= dq;
		end
	end

endmodule

// File: tests/mem_port_chk.sv
`timescale 1ns/1ps

module mem_port_chk (
	input logic                     clk,
	input logic                     rst,
	input mem_types_pkg::exe_req_t  exe,
	input mem_types_pkg::sram_ctl_t sram_ctl,
	input logic                     drive,
	input logic                     exe_done,
	input logic                     if_done,
	input logic                     err
);

	int unsigned fail_count = 0;

	// Idle levels on the first clock after reset release
	a_reset_state: assert property (@(posedge clk)
		$rose(rst) |-> (sram_ctl.oe_n && sram_ctl.we_n && !drive &&
			exe_done && if_done && !err))
	else begin
		fail_count++;
		$error("pins or done levels not idle after reset");
	end

	// Write strobe only with data on the bus
	a_we_drive: assert property (@(posedge clk) disable iff (!rst)
		!sram_ctl.we_n |-> drive)
	else begin
		fail_count++;
		$error("write strobe low while the data bus is not driven");
	end

	a_we_oe: assert property (@(posedge clk) disable iff (!rst)
		!sram_ctl.we_n |-> sram_ctl.oe_n)
	else begin
		fail_count++;
		$error("output enable low during a write strobe");
	end

	// No bus fight between SRAM and DUT
	a_oe_drive: assert property (@(posedge clk) disable iff (!rst)
		!sram_ctl.oe_n |-> !drive)
	else begin
		fail_count++;
		$error("DUT drives the data bus while the SRAM output is enabled");
	end

	// Fetch may not start while execute was asking at that tick
	a_exe_first: assert property (@(posedge clk) disable iff (!rst)
		$fell(if_done) |-> !$past(exe.req))
	else begin
		fail_count++;
		$error("fetch access started over a pending execute request");
	end

	// Error state is sticky
	a_err_sticky: assert property (@(posedge clk) disable iff (!rst)
		err |=> err)
	else begin
		fail_count++;
		$error("err dropped without a reset");
	end

endmodule

// File: tests/tb_mem_port.sv
`timescale 1ns/1ps

module tb_mem_port;
	import mem_types_pkg::*;

	// About 50 accesses at up to 20 clocks each, plus resets and margin
	localparam int TIMEOUT_CYCLES = 3000;

	logic           clk;
	logic           rst;
	exe_req_t       exe;
	logic           if_req;
	mem_addr_t      if_addr;
	logic           exe_done;
	mem_word_t      exe_rdata;
	logic           if_done;
	mem_word_t      if_rdata;
	logic           err;
	mem_addr_t      sram_addr;
	wire mem_word_t sram_dq;
	sram_ctl_t      sram_ctl;

	integer    seed;
	int        errors = 0;
	int        cycles;
	logic      timed_out = 1'b0;
	mem_word_t shadow [mem_addr_t];
	mem_addr_t written [$];

	mem_port_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.exe       (exe),
		.if_req    (if_req),
		.if_addr   (if_addr),
		.exe_done  (exe_done),
		.exe_rdata (exe_rdata),
		.if_done   (if_done),
		.if_rdata  (if_rdata),
		.err       (err),
		.sram_addr (sram_addr),
		.sram_dq   (sram_dq),
		.sram_ctl  (sram_ctl)
	);

	sram_model i_sram (
		.addr (sram_addr),
		.dq   (sram_dq),
		.ce_n (sram_ctl.ce_n),
		.oe_n (sram_ctl.oe_n),
		.we_n (sram_ctl.we_n)
	);

	bind mem_port_top mem_port_chk i_chk (
		.clk      (clk),
		.rst      (rst),
		.exe      (exe),
		.sram_ctl (sram_ctl),
		.drive    (drive),
		.exe_done (exe_done),
		.if_done  (if_done),
		.err      (err)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Drive point, a little after the rising edge
	task automatic step();
		@(posedge clk);
		#10;
	endtask

	task automatic hold_reset();
		rst = 1'b0;
		repeat (16) step();
		rst = 1'b1;
	endtask

	task automatic compare(input string who, input mem_addr_t a, input mem_word_t got);
		if (got !== shadow[a]) begin
			errors++;
			$display("ERR %0t ns: %s read of %05h returned %04h, expected %04h",
				$time, who, a, got, shadow[a]);
		end
	endtask

	task automatic exe_access(input logic rd, input logic wr, input mem_addr_t a,
		input mem_word_t d);
		exe = '{req: 1'b1, rd: rd, wr: wr, addr: a, wdata: d};
		// Done drops as the access starts and rises as it ends
		do step(); while (exe_done);
		do step(); while (!exe_done);
		exe.req = 1'b0;
	endtask

	task automatic write_word(input mem_addr_t a, input mem_word_t d);
		exe_access(1'b0, 1'b1, a, d);
		shadow[a] = d;
		written.push_back(a);
	endtask

	task automatic read_exe(input mem_addr_t a);
		exe_access(1'b1, 1'b0, a, '0);
		compare("execute", a, exe_rdata);
	endtask

	task automatic read_fetch(input mem_addr_t a);
		if_req  = 1'b1;
		if_addr = a;
		do step(); while (if_done);
		do step(); while (!if_done);
		if_req = 1'b0;
		compare("fetch", a, if_rdata);
	endtask

	task automatic finish_run();
		int fails;
		fails = i_dut.i_chk.fail_count;
		$display("Checks done: %0d data errors, %0d assertion failures, timeout %0d",
			errors, fails, timed_out);
		if (errors == 0 && fails == 0 && !timed_out) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		mem_addr_t   a;
		mem_word_t   d;
		logic [31:0] rnd;
		seed    = 32'h9d0c1184;
		exe     = '0;
		if_req  = 1'b0;
		if_addr = '0;
		hold_reset();

		// Write then read back, one fixed pair then random pairs
		write_word(18'h00010, 16'hbeef);
		read_exe(18'h00010);
		repeat (16) begin
			rnd = $random(seed);
			a   = rnd[17:0];
			rnd = $random(seed);
			d   = rnd[15:0];
			write_word(a, d);
			read_exe(a);
		end

		// Fetch reads of words written above
		for (int i = 0; i < 4; i++) begin
			read_fetch(written[i * 4]);
		end

		// Both requesters at once
		write_word(18'h3ff00, 16'h5a5a);
		fork
			read_exe(written[1]);
			read_fetch(18'h3ff00);
		join

		// Illegal request, held in error until reset
		exe = '{req: 1'b1, rd: 1'b0, wr: 1'b0, addr: 18'h00123, wdata: '0};
		do step(); while (!err);
		exe.req = 1'b0;
		repeat (8) step();
		if (!err) begin
			errors++;
			$display("ERR %0t ns: err low after an illegal request, expected high", $time);
		end
		hold_reset();
		write_word(18'h00123, 16'hc0de);
		read_exe(18'h00123);

		finish_run();
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		timed_out = 1'b1;
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		finish_run();
	end

endmodule

// File: mem_port_top.f
src/mem_types_pkg.sv
src/ram_timing_pkg.sv
src/ram_ctrl.sv
src/ram_bus_io.sv
src/mem_port_top.sv
tests/sram_model.sv
tests/mem_port_chk.sv
tests/tb_mem_port.sv

// File: Makefile
TOP = tb_mem_port

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation, log in sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f mem_port_top.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
